// ==== logic/gpgpu_pkg.sv ====
`default_nettype none

package gpgpu_pkg;

	localparam int BEATS_PER_LINE = 4;            // 32-bit beats per 16-byte line

	typedef logic [31:0]  word_t;                 // One AXI beat
	typedef logic [127:0] line_t;                 // Word 0 in bits 31:0
	typedef logic [27:0]  line_addr_t;            // Byte address bits 31:4
	typedef logic [0:0]   core_index_t;
	typedef logic [15:0]  count_t;                // Saturating event count

	typedef enum logic
	{
		load  = 1'b0,
		store = 1'b1
	} l2_op_t;

	typedef struct packed
	{
		l2_op_t      op;
		core_index_t core;
		line_addr_t  address;
		line_t       data;                        // Ignored for loads
	} l2_req_t;

	typedef struct packed
	{
		core_index_t core;
		l2_op_t      op;
		line_addr_t  address;
		line_t       data;                        // Loaded line of a load response
	} l2_rsp_t;

	typedef struct packed
	{
		count_t read_bursts;
		count_t write_bursts;
		count_t ar_stall_cycles;
		count_t w_stall_cycles;
	} perf_count_t;

endpackage

`default_nettype wire

// ==== logic/copy_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module copy_core
	#(parameter gpgpu_pkg::core_index_t CORE_ID = 1'b0,
	parameter int LINE_COUNT = 8,
	parameter gpgpu_pkg::line_addr_t SRC_BASE = 28'h0000100,
	parameter gpgpu_pkg::line_addr_t DST_BASE = 28'h0000200)
	(input wire clk,
	input wire reset,
	output logic req_valid,
	output gpgpu_pkg::l2_req_t req,
	input wire req_ready,
	input wire rsp_valid,
	input wire gpgpu_pkg::l2_rsp_t rsp,
	output logic halt);

	localparam int COUNT_W = $clog2(LINE_COUNT + 1);

	// First line of this core's slice in each region
	localparam gpgpu_pkg::line_addr_t SRC_START = SRC_BASE
		+ gpgpu_pkg::line_addr_t'(CORE_ID) * gpgpu_pkg::line_addr_t'(LINE_COUNT);
	localparam gpgpu_pkg::line_addr_t DST_START = DST_BASE
		+ gpgpu_pkg::line_addr_t'(CORE_ID) * gpgpu_pkg::line_addr_t'(LINE_COUNT);

	typedef enum logic [2:0]
	{
		issue_load,
		wait_load,
		issue_store,
		wait_store,
		done
	} core_state_t;

	core_state_t state;
	logic [COUNT_W-1:0] line_count;               // Lines fully copied so far
	gpgpu_pkg::line_t load_data;
	logic rsp_hit;
	logic last_line;

	assign rsp_hit = rsp_valid && (rsp.core == CORE_ID);
	assign last_line = line_count == COUNT_W'(LINE_COUNT - 1);
	assign halt = state == done;

	always_comb
	begin
		req.core = CORE_ID;
		req.data = load_data;
		if (state == issue_store)
		begin
			req.op = gpgpu_pkg::store;
			req.address = DST_START + gpgpu_pkg::line_addr_t'(line_count);
		end
		else
		begin
			req.op = gpgpu_pkg::load;
			req.address = SRC_START + gpgpu_pkg::line_addr_t'(line_count);
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= issue_load;
			req_valid <= 1'b0;
			line_count <= '0;
		end
		else
		begin
			case (state)
				issue_load:
				begin
					if (!req_valid)
						req_valid <= 1'b1;    // First request after reset
					else if (req_ready)
					begin
						req_valid <= 1'b0;
						state <= wait_load;
					end
				end

				wait_load:
				begin
					if (rsp_hit)
					begin
						req_valid <= 1'b1;
						state <= issue_store;
					end
				end

				issue_store:
				begin
					if (req_ready)
					begin
						req_valid <= 1'b0;
						state <= wait_store;
					end
				end

				wait_store:
				begin
					if (rsp_hit)
					begin
						line_count <= line_count + 1'b1;
						if (last_line)
							state <= done;
						else
						begin
							req_valid <= 1'b1;
							state <= issue_load;
						end
					end
				end

				default: ;                    // Halt stays high in done
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == wait_load && rsp_hit)
			load_data <= rsp.data;
	end

endmodule

`default_nettype wire

// ==== logic/l2_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module l2_arbiter
	(input wire clk,
	input wire reset,
	input wire req_valid0,
	input wire gpgpu_pkg::l2_req_t req0,
	input wire req_valid1,
	input wire gpgpu_pkg::l2_req_t req1,
	output logic req_ready0,
	output logic req_ready1,
	output logic req_valid,
	output gpgpu_pkg::l2_req_t req,
	input wire req_ready);

	gpgpu_pkg::core_index_t last_grant;
	gpgpu_pkg::core_index_t select;

	// Alternate on conflict, otherwise take whoever is waiting
	always_comb
	begin
		if (req_valid0 && req_valid1)
			select = ~last_grant;
		else if (req_valid1)
			select = 1'b1;
		else
			select = 1'b0;
	end

	assign req_valid = req_valid0 || req_valid1;
	assign req = select ? req1 : req0;
	assign req_ready0 = req_ready && (select == 1'b0);
	assign req_ready1 = req_ready && (select == 1'b1);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			last_grant <= 1'b1;               // Core 0 wins the first tie
		else if (req_valid && req_ready)
			last_grant <= select;
	end

endmodule

`default_nettype wire

// ==== logic/line_axi_bridge.sv ====
`default_nettype none
`timescale 1ns/1ps

module line_axi_bridge
	(input wire clk,
	input wire reset,
	input wire req_valid,
	input wire gpgpu_pkg::l2_req_t req,
	output logic req_ready,
	output logic rsp_valid,
	output gpgpu_pkg::l2_rsp_t rsp,
	output logic [31:0] awaddr,
	output logic [7:0] awlen,
	output logic awvalid,
	input wire awready,
	output gpgpu_pkg::word_t wdata,
	output logic wlast,
	output logic wvalid,
	input wire wready,
	input wire bvalid,
	output logic bready,
	output logic [31:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	input wire arready,
	input wire rvalid,
	input wire gpgpu_pkg::word_t rdata,
	output logic rready);

	typedef enum logic [2:0]
	{
		idle,
		read_addr,
		read_data,
		write_addr,
		write_data,
		write_resp,
		respond
	} bridge_state_t;

	bridge_state_t state;
	gpgpu_pkg::l2_req_t req_q;                    // Request in flight
	gpgpu_pkg::line_t line_q;                     // Read beats collect here
	logic [1:0] beat_count;
	logic last_beat;

	assign last_beat = beat_count == 2'(gpgpu_pkg::BEATS_PER_LINE - 1);

	assign req_ready = state == idle;
	assign arvalid = state == read_addr;
	assign rready = state == read_data;
	assign awvalid = state == write_addr;
	assign wvalid = state == write_data;
	assign bready = state == write_resp;
	assign rsp_valid = state == respond;

	assign araddr = {req_q.address, 4'h0};
	assign awaddr = {req_q.address, 4'h0};
	assign arlen = 8'(gpgpu_pkg::BEATS_PER_LINE - 1);
	assign awlen = 8'(gpgpu_pkg::BEATS_PER_LINE - 1);
	assign wdata = req_q.data[32 * beat_count +: 32]; // Ascending words
	assign wlast = last_beat;

	assign rsp.core = req_q.core;
	assign rsp.op = req_q.op;
	assign rsp.address = req_q.address;
	assign rsp.data = line_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= idle;
			beat_count <= 2'd0;
		end
		else
		begin
			case (state)
				idle:
				begin
					beat_count <= 2'd0;
					if (req_valid)
						state <= (req.op == gpgpu_pkg::load) ? read_addr : write_addr;
				end

				read_addr:
					if (arready)
						state <= read_data;

				read_data:
				begin
					if (rvalid)
					begin
						beat_count <= beat_count + 2'd1;
						if (last_beat)
							state <= respond;
					end
				end

				write_addr:
					if (awready)
						state <= write_data;  // W only after AW

				write_data:
				begin
					if (wready)
					begin
						beat_count <= beat_count + 2'd1;
						if (last_beat)
							state <= write_resp;
					end
				end

				write_resp:
					if (bvalid)
						state <= respond;

				default:
					state <= idle;            // Respond lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == idle && req_valid)
			req_q <= req;
		if (state == read_data && rvalid)
			line_q <= {rdata, line_q[127:32]}; // First beat ends up in word 0
	end

endmodule

`default_nettype wire

// ==== logic/perf_counters.sv ====
`default_nettype none
`timescale 1ns/1ps

module perf_counters
	(input wire clk,
	input wire reset,
	input wire arvalid,
	input wire arready,
	input wire awvalid,
	input wire awready,
	input wire wvalid,
	input wire wready,
	output gpgpu_pkg::perf_count_t counts);

	// Increment on event, stick at all ones
	function automatic gpgpu_pkg::count_t bump(gpgpu_pkg::count_t value, logic event_hit);
		if (event_hit && value != '1)
			return value + 1'b1;
		return value;
	endfunction

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			counts <= '0;
		else
		begin
			counts.read_bursts <= bump(counts.read_bursts, arvalid && arready);
			counts.write_bursts <= bump(counts.write_bursts, awvalid && awready);
			counts.ar_stall_cycles <= bump(counts.ar_stall_cycles, arvalid && !arready);
			counts.w_stall_cycles <= bump(counts.w_stall_cycles, wvalid && !wready);
		end
	end

endmodule

`default_nettype wire

// ==== logic/gpgpu_lite.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpgpu_lite
	#(parameter int LINE_COUNT = 8,
	parameter gpgpu_pkg::line_addr_t SRC_BASE = 28'h0000100,
	parameter gpgpu_pkg::line_addr_t DST_BASE = 28'h0000200)
	(input wire clk,
	input wire reset,
	output logic processor_halt,
	output gpgpu_pkg::perf_count_t counts,

	// External memory port
	output logic [31:0] awaddr,
	output logic [7:0] awlen,
	output logic awvalid,
	input wire awready,
	output gpgpu_pkg::word_t wdata,
	output logic wlast,
	output logic wvalid,
	input wire wready,
	input wire bvalid,
	output logic bready,
	output logic [31:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	input wire arready,
	input wire rvalid,
	input wire gpgpu_pkg::word_t rdata,
	output logic rready);

	logic req_valid0;
	logic req_valid1;
	logic req_ready0;
	logic req_ready1;
	logic req_valid;
	logic req_ready;
	logic rsp_valid;
	logic halt0;
	logic halt1;
	gpgpu_pkg::l2_req_t req0;
	gpgpu_pkg::l2_req_t req1;
	gpgpu_pkg::l2_req_t req;
	gpgpu_pkg::l2_rsp_t rsp;                      // Broadcast to both cores

	assign processor_halt = halt0 && halt1;

	copy_core #(.CORE_ID(1'b0), .LINE_COUNT(LINE_COUNT), .SRC_BASE(SRC_BASE),
		.DST_BASE(DST_BASE)) core0(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid0),
		.req(req0),
		.req_ready(req_ready0),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.halt(halt0));

	copy_core #(.CORE_ID(1'b1), .LINE_COUNT(LINE_COUNT), .SRC_BASE(SRC_BASE),
		.DST_BASE(DST_BASE)) core1(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid1),
		.req(req1),
		.req_ready(req_ready1),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.halt(halt1));

	l2_arbiter arb0(
		.clk(clk),
		.reset(reset),
		.req_valid0(req_valid0),
		.req0(req0),
		.req_valid1(req_valid1),
		.req1(req1),
		.req_ready0(req_ready0),
		.req_ready1(req_ready1),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready));

	line_axi_bridge bridge0(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.awaddr(awaddr),
		.awlen(awlen),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wlast(wlast),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rready(rready));

	perf_counters perf0(
		.clk(clk),
		.reset(reset),
		.arvalid(arvalid),
		.arready(arready),
		.awvalid(awvalid),
		.awready(awready),
		.wvalid(wvalid),
		.wready(wready),
		.counts(counts));

endmodule

`default_nettype wire

// ==== sim/tb_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_checker
	#(parameter int LINE_COUNT = 8,
	parameter gpgpu_pkg::line_addr_t SRC_BASE = 28'h0000100,
	parameter gpgpu_pkg::line_addr_t DST_BASE = 28'h0000200)
	(input wire clk,
	input wire reset,
	input wire processor_halt,
	input wire gpgpu_pkg::perf_count_t counts,
	input wire [31:0] awaddr,
	input wire [7:0] awlen,
	input wire awvalid,
	input wire awready,
	input wire gpgpu_pkg::word_t wdata,
	input wire wlast,
	input wire wvalid,
	input wire wready,
	input wire bvalid,
	input wire bready,
	input wire [31:0] araddr,
	input wire [7:0] arlen,
	input wire arvalid,
	input wire arready,
	input wire rvalid,
	input wire gpgpu_pkg::word_t rdata,
	input wire rready,
	output int errors,
	output int checks);

	localparam int TOTAL = 2 * LINE_COUNT;

	logic read_seen [TOTAL];                      // Source lines fetched so far
	logic written [TOTAL];
	int ar_count;
	int aw_count;
	int ar_stalls;
	int w_stalls;
	int w_beat;
	gpgpu_pkg::line_addr_t aw_src;                // Source of the line being stored
	logic left_reset;
	logic halt_seen;

	// Expected content of any source word
	function automatic gpgpu_pkg::word_t expected_word(logic [31:0] byte_addr);
		return {byte_addr[18:0], byte_addr[31:19]} ^ 32'h3c5a_96e1;
	endfunction

	function automatic gpgpu_pkg::line_addr_t source_line(gpgpu_pkg::line_addr_t dst);
		return dst - DST_BASE + SRC_BASE;
	endfunction

	task automatic compare_value(string name, logic [63:0] actual, logic [63:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic report_failure(string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		left_reset = 1'b0;
		halt_seen = 1'b0;
	end

	// Sample on the falling edge between drive edges
	always @(negedge clk)
	begin
		int idx;
		gpgpu_pkg::line_addr_t line;
		if (reset || !left_reset)
		begin
			compare_value("arvalid", arvalid, 0);
			compare_value("awvalid", awvalid, 0);
			compare_value("wvalid", wvalid, 0);
			compare_value("rready", rready, 0);
			compare_value("bready", bready, 0);
			compare_value("processor_halt", processor_halt, 0);
			compare_value("counts", counts, 0);
			for (int i = 0; i < TOTAL; i++)
			begin
				read_seen[i] = 1'b0;
				written[i] = 1'b0;
			end
			ar_count = 0;
			aw_count = 0;
			ar_stalls = 0;
			w_stalls = 0;
			w_beat = 0;
			if (!reset)
				left_reset = 1'b1;
		end
		else
		begin
			if (arvalid && !arready)
				ar_stalls++;
			if (wvalid && !wready)
				w_stalls++;

			// Read data and write response are never stalled by the DUT
			if (rvalid)
				compare_value("rready", rready, 1);
			if (bvalid)
				compare_value("bready", bready, 1);

			if (arvalid && arready)
			begin
				ar_count++;
				line = araddr[31:4];
				compare_value("araddr[3:0]", araddr[3:0], 0);
				compare_value("arlen", arlen, 3);
				if (line < SRC_BASE || line >= SRC_BASE + TOTAL)
					report_failure($sformatf("read address %h is outside the source lines", araddr));
				else
					read_seen[int'(line - SRC_BASE)] = 1'b1;
			end

			if (awvalid && awready)
			begin
				aw_count++;
				line = awaddr[31:4];
				aw_src = source_line(line);
				w_beat = 0;
				compare_value("awaddr[3:0]", awaddr[3:0], 0);
				compare_value("awlen", awlen, 3);
				if (line < DST_BASE || line >= DST_BASE + TOTAL)
					report_failure($sformatf("write address %h is outside the destination lines",
						awaddr));
				else
				begin
					idx = int'(line - DST_BASE);
					if (written[idx])
						report_failure($sformatf("destination line %h written twice", line));
					if (!read_seen[int'(aw_src - SRC_BASE)])
						report_failure($sformatf("line %h stored before its source was read", line));
					written[idx] = 1'b1;
				end
			end

			if (wvalid && wready)
			begin
				compare_value("wdata", wdata, expected_word({aw_src, 4'h0} + 32'(4 * w_beat)));
				compare_value("wlast", wlast, w_beat == gpgpu_pkg::BEATS_PER_LINE - 1);
				w_beat++;
			end

			if (halt_seen && !processor_halt)
				report_failure("processor_halt fell after it had risen");
			if (processor_halt && !halt_seen)
			begin
				halt_seen = 1'b1;
				compare_value("AR transfers", ar_count, TOTAL);
				compare_value("AW transfers", aw_count, TOTAL);
				for (int i = 0; i < TOTAL; i++)
					if (!written[i])
						report_failure($sformatf("destination line %0d never written", i));
				compare_value("counts.read_bursts", counts.read_bursts, ar_count);
				compare_value("counts.write_bursts", counts.write_bursts, aw_count);
				compare_value("counts.ar_stall_cycles", counts.ar_stall_cycles, ar_stalls);
				compare_value("counts.w_stall_cycles", counts.w_stall_cycles, w_stalls);
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_gpgpu.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_gpgpu;

	localparam int LINE_COUNT = 8;
	localparam gpgpu_pkg::line_addr_t SRC_BASE = 28'h0000100;
	localparam gpgpu_pkg::line_addr_t DST_BASE = 28'h0000200;
	localparam int TIMEOUT_CYCLES = 2 * LINE_COUNT * 2 * 200;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic processor_halt;
	gpgpu_pkg::perf_count_t counts;
	logic [31:0] awaddr;
	logic [7:0] awlen;
	logic awvalid;
	logic awready = 1'b0;
	gpgpu_pkg::word_t wdata;
	logic wlast;
	logic wvalid;
	logic wready = 1'b0;
	logic bvalid = 1'b0;
	logic bready;
	logic [31:0] araddr;
	logic [7:0] arlen;
	logic arvalid;
	logic arready = 1'b0;
	logic rvalid = 1'b0;
	gpgpu_pkg::word_t rdata = '0;
	logic rready;
	int errors;
	int checks;
	integer seed = 32'h7ef;

	// External memory model state
	gpgpu_pkg::word_t mem [logic [31:0]];         // Only words the DUT has written
	logic rd_active = 1'b0;
	logic [31:0] rd_addr = '0;
	logic [1:0] rd_beat = 2'd0;
	logic wr_active = 1'b0;
	logic [31:0] wr_addr = '0;
	logic [1:0] wr_beat = 2'd0;

	// Background fill mixing every address bit
	function automatic gpgpu_pkg::word_t fill_word(logic [31:0] addr);
		return {addr[18:0], addr[31:19]} ^ 32'h3c5a_96e1;
	endfunction

	function automatic gpgpu_pkg::word_t read_word(logic [31:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return fill_word(addr);
	endfunction

	always #10 clk = ~clk;

	gpgpu_lite #(.LINE_COUNT(LINE_COUNT), .SRC_BASE(SRC_BASE), .DST_BASE(DST_BASE)) dut0(
		.clk(clk),
		.reset(reset),
		.processor_halt(processor_halt),
		.counts(counts),
		.awaddr(awaddr),
		.awlen(awlen),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wlast(wlast),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rready(rready));

	tb_checker #(.LINE_COUNT(LINE_COUNT), .SRC_BASE(SRC_BASE), .DST_BASE(DST_BASE)) chk0(
		.clk(clk),
		.reset(reset),
		.processor_halt(processor_halt),
		.counts(counts),
		.awaddr(awaddr),
		.awlen(awlen),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wlast(wlast),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rready(rready),
		.errors(errors),
		.checks(checks));

	always @(posedge clk)
	begin
		integer roll;
		roll = $random(seed);                     // One draw per cycle for all readies
		if (reset)
		begin
			arready <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
			rd_active <= 1'b0;
			wr_active <= 1'b0;
		end
		else
		begin
			if (arvalid && arready)
			begin
				arready <= 1'b0;
				rd_active <= 1'b1;
				rd_addr <= araddr;
				rd_beat <= 2'd0;
			end
			else
				arready <= arvalid && !rd_active && (roll[1:0] != 2'b00);

			if (rd_active)
			begin
				if (rvalid && rready)
				begin
					rvalid <= 1'b0;
					rd_beat <= rd_beat + 2'd1;
					if (rd_beat == 2'd3)
						rd_active <= 1'b0;   // Burst complete
				end
				else if (!rvalid && roll[3:2] != 2'b00)
				begin
					rvalid <= 1'b1;
					rdata <= read_word(rd_addr + {28'd0, rd_beat, 2'b00});
				end
			end

			if (awvalid && awready)
			begin
				awready <= 1'b0;
				wr_active <= 1'b1;
				wr_addr <= awaddr;
				wr_beat <= 2'd0;
			end
			else
				awready <= awvalid && !wr_active && (roll[5:4] != 2'b00);

			if (wr_active)
			begin
				if (bvalid)
				begin
					if (bready)
					begin
						bvalid <= 1'b0;
						wr_active <= 1'b0;
					end
				end
				else if (wvalid && wready)
				begin
					mem[wr_addr + {28'd0, wr_beat, 2'b00}] = wdata;
					wready <= 1'b0;
					wr_beat <= wr_beat + 2'd1;
					if (wr_beat == 2'd3)
						bvalid <= 1'b1;
				end
				else
					wready <= roll[7:6] != 2'b00;
			end
		end
	end

	initial
	begin
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		while (processor_halt !== 1'b1)
			@(posedge clk);
		repeat (8) @(posedge clk);                // Halt must stay up meanwhile
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0 && checks > 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: processor_halt did not rise within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks %0d, errors %0d", checks, errors + 1);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
logic/gpgpu_pkg.sv
logic/copy_core.sv
logic/l2_arbiter.sv
logic/line_axi_bridge.sv
logic/perf_counters.sv
logic/gpgpu_lite.sv
sim/tb_checker.sv
sim/tb_gpgpu.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP       = tb_gpgpu
RTL_TOP   = gpgpu_lite
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
